// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tlb_selftest
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/tlb_pkg.sv ====
// shared TLB self-test definitions; STEP_CYCLES and SCAN_SHIFT are sized for simulation only
package tlb_pkg;

    localparam int TLBNUM = 16;
    localparam int IDX_W = $clog2(TLBNUM);
    localparam int VPPN_W = 19;
    localparam int ASID_W = 10;
    localparam int PPN_W = 20;
    localparam int PS_W = 6;
    localparam int PLV_W = 2;
    localparam int MAT_W = 2;

    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd21;
    // 4 MB pages ignore the vppn bits below this one
    localparam int BIG_LSB = 9;

    localparam int SEARCH_PAIRS = 13;
    localparam int PAIR_W = 4;
    localparam int ID_W = PAIR_W + 1;
    localparam int STEP_CYCLES = 4;
    localparam int STEP_W = $clog2(STEP_CYCLES);
    // a display digit is held for 2**SCAN_SHIFT cycles
    localparam int SCAN_SHIFT = 5;
    localparam int DIGITS = 8;
    localparam int SEG_W = 7;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_RUN,
        PH_DONE
    } test_phase_t;

    // field order matches the write and read port concatenations
    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PPN_W-1:0]  ppn0;
        logic [PLV_W-1:0]  plv0;
        logic [MAT_W-1:0]  mat0;
        logic              d0;
        logic              v0;
        logic [PPN_W-1:0]  ppn1;
        logic [PLV_W-1:0]  plv1;
        logic [MAT_W-1:0]  mat1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              va_bit12;
        logic [ASID_W-1:0] asid;
        logic              found;
        logic [IDX_W-1:0]  index;
        logic [PPN_W-1:0]  ppn;
        logic [PS_W-1:0]   ps;
        logic [PLV_W-1:0]  plv;
        logic [MAT_W-1:0]  mat;
        logic              d;
        logic              v;
    } search_vec_t;

    function automatic tlb_entry_t entry_table(input logic [IDX_W-1:0] idx);
        tlb_entry_t       ent;
        logic [IDX_W-1:0] base;
        // entries 5 and 7 reuse the vppn of 4 and 6 under their own asid
        base = (idx == 4'd5 || idx == 4'd7) ? idx - 4'd1 : idx;
        ent = '0;
        ent.e = 1'b1;
        ent.vppn = {15'd0, base} * 19'h111;
        ent.ps = PS_4K;
        ent.asid = {6'd0, idx};
        ent.g = (idx == 4'd1 || idx == 4'd3);
        ent.ppn0 = ({16'd0, idx} + 20'd1) * 20'h111;
        ent.ppn1 = {16'd0, idx + 4'd2} * 20'h11;
        ent.mat0 = 2'd1;
        ent.d0 = 1'b1;
        ent.v0 = 1'b1;
        ent.mat1 = 2'd1;
        ent.d1 = 1'b1;
        ent.v1 = 1'b1;
        if (idx == 4'd0 || idx == 4'd15) begin
            // large pages sit at both ends of the table
            ent.ps = PS_4M;
            ent.vppn = (idx == 4'd0) ? 19'h1000 : 19'hf000;
            ent.ppn0 = (idx == 4'd0) ? 20'h1000 : 20'h2000;
            ent.ppn1 = ent.ppn0 + 20'h100;
        end
        return ent;
    endfunction

    function automatic search_vec_t mk_hit(input logic [VPPN_W-1:0] vppn, input logic va_bit12,
                                           input logic [ASID_W-1:0] asid,
                                           input logic [IDX_W-1:0] index,
                                           input logic [PPN_W-1:0] ppn, input logic [PS_W-1:0] ps);
        return '{vppn, va_bit12, asid, 1'b1, index, ppn, ps, 2'd0, 2'd1, 1'b1, 1'b1};
    endfunction

    function automatic search_vec_t mk_miss(input logic [VPPN_W-1:0] vppn, input logic va_bit12,
                                            input logic [ASID_W-1:0] asid);
        return '{vppn, va_bit12, asid, 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b0};
    endfunction

    // even ids go to search port 0, odd ids to port 1
    function automatic search_vec_t search_vector(input logic [ID_W-1:0] id);
        case (id)
            5'd0:    return mk_hit(19'h1000, 1'b1, 10'h0, 4'h0, 20'h1000, PS_4M);
            5'd1:    return mk_hit(19'h1100, 1'b0, 10'h0, 4'h0, 20'h1100, PS_4M);
            5'd2:    return mk_miss(19'h1000, 1'b1, 10'h1);
            5'd3:    return mk_hit(19'h111, 1'b1, 10'h0, 4'h1, 20'h033, PS_4K);
            5'd4:    return mk_hit(19'h111, 1'b0, 10'h1, 4'h1, 20'h222, PS_4K);
            5'd5:    return mk_miss(19'h222, 1'b0, 10'h0);
            5'd6:    return mk_hit(19'h222, 1'b0, 10'h2, 4'h2, 20'h333, PS_4K);
            5'd7:    return mk_hit(19'h333, 1'b0, 10'h3, 4'h3, 20'h444, PS_4K);
            5'd8:    return mk_hit(19'h333, 1'b1, 10'h4, 4'h3, 20'h055, PS_4K);
            5'd9:    return mk_hit(19'h444, 1'b0, 10'h4, 4'h4, 20'h555, PS_4K);
            5'd10:   return mk_hit(19'h444, 1'b0, 10'h5, 4'h5, 20'h666, PS_4K);
            5'd11:   return mk_miss(19'h555, 1'b1, 10'h5);
            5'd12:   return mk_hit(19'h666, 1'b0, 10'h6, 4'h6, 20'h777, PS_4K);
            5'd13:   return mk_hit(19'h666, 1'b1, 10'h7, 4'h7, 20'h099, PS_4K);
            5'd14:   return mk_miss(19'h666, 1'b1, 10'h8);
            5'd15:   return mk_miss(19'h777, 1'b0, 10'h7);
            5'd16:   return mk_hit(19'h888, 1'b0, 10'h8, 4'h8, 20'h999, PS_4K);
            5'd17:   return mk_hit(19'h999, 1'b1, 10'h9, 4'h9, 20'h0bb, PS_4K);
            5'd18:   return mk_hit(19'haaa, 1'b0, 10'ha, 4'ha, 20'hbbb, PS_4K);
            5'd19:   return mk_hit(19'hbbb, 1'b1, 10'hb, 4'hb, 20'h0dd, PS_4K);
            5'd20:   return mk_hit(19'hccc, 1'b0, 10'hc, 4'hc, 20'hddd, PS_4K);
            5'd21:   return mk_hit(19'hddd, 1'b1, 10'hd, 4'hd, 20'h0ff, PS_4K);
            5'd22:   return mk_hit(19'heee, 1'b0, 10'he, 4'he, 20'hfff, PS_4K);
            5'd23:   return mk_hit(19'hf000, 1'b0, 10'hf, 4'hf, 20'h2000, PS_4M);
            5'd24:   return mk_miss(19'habc, 1'b0, 10'hf);
            default: return mk_miss(19'h123, 1'b1, 10'h3);
        endcase
    endfunction

    // active-high segments, a in the top bit
    function automatic logic [SEG_W-1:0] seg_code(input logic [3:0] digit);
        case (digit)
            4'h0:    return 7'b1111110;
            4'h1:    return 7'b0110000;
            4'h2:    return 7'b1101101;
            4'h3:    return 7'b1111001;
            4'h4:    return 7'b0110011;
            4'h5:    return 7'b1011011;
            4'h6:    return 7'b1011111;
            4'h7:    return 7'b1110000;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1111011;
            4'ha:    return 7'b1110111;
            4'hb:    return 7'b0011111;
            4'hc:    return 7'b1001110;
            4'hd:    return 7'b0111101;
            4'he:    return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

endpackage

// ==== hw/selftest_status.sv ====
// led bits are active low; num_a_g trails num_csn by one clock because the digit is registered twice
`timescale 1ns/1ps

module selftest_status
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              resetn,
    input  logic              write_done,
    input  logic              read_done,
    input  logic              search_done,
    input  logic              read_err,
    input  logic              search_err,
    input  logic [IDX_W-1:0]  w_cnt,
    input  logic [IDX_W-1:0]  r_cnt,
    input  logic [PAIR_W-1:0] pair_cnt,
    output logic [15:0]       led,
    output logic [DIGITS-1:0] num_csn,
    output logic [SEG_W-1:0]  num_a_g
);

    logic                  test_error;
    logic [SCAN_SHIFT+2:0] scan_cnt;
    logic [2:0]            sel;
    logic [3:0]            scan_data;

    // an error only counts while the matching checker is still running
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            test_error <= 1'b0;
        end else if (write_done && ((!read_done && read_err) || (!search_done && search_err))) begin
            test_error <= 1'b1;
        end
    end

    assign sel = scan_cnt[SCAN_SHIFT +: 3];

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            scan_cnt <= '0;
            scan_data <= '0;
            num_csn <= '1;
            num_a_g <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            num_csn <= ~(8'h80 >> sel);
            num_a_g <= seg_code(scan_data);
            // left to right: port 1 id, port 0 id, read index, write index
            case (sel)
                3'd0: scan_data <= {3'b000, pair_cnt[3]};
                3'd1: scan_data <= {pair_cnt[2:0], 1'b1};
                3'd2: scan_data <= {3'b000, pair_cnt[3]};
                3'd3: scan_data <= {pair_cnt[2:0], 1'b0};
                3'd5: scan_data <= r_cnt;
                3'd7: scan_data <= w_cnt;
                default: scan_data <= 4'h0;
            endcase
        end
    end

    assign led = {~test_error, 12'hfff, ~write_done, ~read_done, ~search_done};

endmodule

// ==== hw/tlb_read_check.sv ====
// read_err is a raw compare and only means something once write_done is high
`timescale 1ns/1ps

module tlb_read_check
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              resetn,
    input  logic              step,
    input  logic              write_done,
    input  logic              r_e,
    input  logic [VPPN_W-1:0] r_vppn,
    input  logic [PS_W-1:0]   r_ps,
    input  logic [ASID_W-1:0] r_asid,
    input  logic              r_g,
    input  logic [PPN_W-1:0]  r_ppn0,
    input  logic [PLV_W-1:0]  r_plv0,
    input  logic [MAT_W-1:0]  r_mat0,
    input  logic              r_d0,
    input  logic              r_v0,
    input  logic [PPN_W-1:0]  r_ppn1,
    input  logic [PLV_W-1:0]  r_plv1,
    input  logic [MAT_W-1:0]  r_mat1,
    input  logic              r_d1,
    input  logic              r_v1,
    output logic [IDX_W-1:0]  r_index,
    output logic [IDX_W-1:0]  r_cnt,
    output logic              read_err,
    output logic              read_done
);

    test_phase_t phase;

    assign r_index = r_cnt;
    assign read_err = {r_e, r_vppn, r_ps, r_asid, r_g, r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                       r_ppn1, r_plv1, r_mat1, r_d1, r_v1} != entry_table(r_cnt);
    assign read_done = (phase == PH_DONE);

    // a mismatch freezes the index so the display shows the failing entry
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            phase <= PH_IDLE;
            r_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: if (write_done) phase <= PH_RUN;
                PH_RUN: begin
                    if (!read_err && r_cnt == IDX_W'(TLBNUM - 1)) begin
                        phase <= PH_DONE;
                    end else if (!read_err && step) begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                default: phase <= phase;
            endcase
        end
    end

endmodule

// ==== hw/tlb_search_check.sv ====
// expected misses check only found; the lookup pair stays put while either port mismatches
`timescale 1ns/1ps

module tlb_search_check
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              resetn,
    input  logic              step,
    input  logic              write_done,
    input  logic              s0_found,
    input  logic [IDX_W-1:0]  s0_index,
    input  logic [PPN_W-1:0]  s0_ppn,
    input  logic [PS_W-1:0]   s0_ps,
    input  logic [PLV_W-1:0]  s0_plv,
    input  logic [MAT_W-1:0]  s0_mat,
    input  logic              s0_d,
    input  logic              s0_v,
    input  logic              s1_found,
    input  logic [IDX_W-1:0]  s1_index,
    input  logic [PPN_W-1:0]  s1_ppn,
    input  logic [PS_W-1:0]   s1_ps,
    input  logic [PLV_W-1:0]  s1_plv,
    input  logic [MAT_W-1:0]  s1_mat,
    input  logic              s1_d,
    input  logic              s1_v,
    output logic [VPPN_W-1:0] s0_vppn,
    output logic              s0_va_bit12,
    output logic [ASID_W-1:0] s0_asid,
    output logic [VPPN_W-1:0] s1_vppn,
    output logic              s1_va_bit12,
    output logic [ASID_W-1:0] s1_asid,
    output logic [PAIR_W-1:0] pair_cnt,
    output logic              search_err,
    output logic              search_done
);

    test_phase_t phase;
    search_vec_t vec0;
    search_vec_t vec1;

    function automatic logic port_err(input search_vec_t want, input logic found,
                                      input logic [IDX_W-1:0] index, input logic [PPN_W-1:0] ppn,
                                      input logic [PS_W-1:0] ps, input logic [PLV_W-1:0] plv,
                                      input logic [MAT_W-1:0] mat, input logic d, input logic v);
        if (!want.found) begin
            return found;
        end
        return !found || {index, ppn, ps, plv, mat, d, v} !=
               {want.index, want.ppn, want.ps, want.plv, want.mat, want.d, want.v};
    endfunction

    assign vec0 = search_vector({pair_cnt, 1'b0});
    assign vec1 = search_vector({pair_cnt, 1'b1});
    assign {s0_vppn, s0_va_bit12, s0_asid} = {vec0.vppn, vec0.va_bit12, vec0.asid};
    assign {s1_vppn, s1_va_bit12, s1_asid} = {vec1.vppn, vec1.va_bit12, vec1.asid};

    assign search_err = port_err(vec0, s0_found, s0_index, s0_ppn, s0_ps, s0_plv, s0_mat,
                                 s0_d, s0_v) ||
                        port_err(vec1, s1_found, s1_index, s1_ppn, s1_ps, s1_plv, s1_mat,
                                 s1_d, s1_v);
    assign search_done = (phase == PH_DONE);

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            phase <= PH_IDLE;
            pair_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: if (write_done) phase <= PH_RUN;
                PH_RUN: begin
                    if (!search_err && pair_cnt == PAIR_W'(SEARCH_PAIRS - 1)) begin
                        phase <= PH_DONE;
                    end else if (!search_err && step) begin
                        pair_cnt <= pair_cnt + 1'b1;
                    end
                end
                default: phase <= phase;
            endcase
        end
    end

endmodule

// ==== hw/tlb_selftest_top.sv ====
// runs straight from clk_g with no PLL; the TLB has no invalidate port
`timescale 1ns/1ps

module tlb_selftest_top
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              resetn,
    output logic [15:0]       led,
    output logic [DIGITS-1:0] num_csn,
    output logic [SEG_W-1:0]  num_a_g
);

    // write port and sequencer status
    logic              step, write_done, we;
    logic [IDX_W-1:0]  w_index, w_cnt;
    logic              w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic [VPPN_W-1:0] w_vppn;
    logic [PS_W-1:0]   w_ps;
    logic [ASID_W-1:0] w_asid;
    logic [PPN_W-1:0]  w_ppn0, w_ppn1;
    logic [PLV_W-1:0]  w_plv0, w_plv1;
    logic [MAT_W-1:0]  w_mat0, w_mat1;

    // read port and read-back checker
    logic [IDX_W-1:0]  r_index, r_cnt;
    logic              r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    logic [VPPN_W-1:0] r_vppn;
    logic [PS_W-1:0]   r_ps;
    logic [ASID_W-1:0] r_asid;
    logic [PPN_W-1:0]  r_ppn0, r_ppn1;
    logic [PLV_W-1:0]  r_plv0, r_plv1;
    logic [MAT_W-1:0]  r_mat0, r_mat1;
    logic              read_err, read_done;

    // both search ports and the search checker
    logic [VPPN_W-1:0] s0_vppn, s1_vppn;
    logic              s0_va_bit12, s1_va_bit12;
    logic [ASID_W-1:0] s0_asid, s1_asid;
    logic              s0_found, s1_found, s0_d, s1_d, s0_v, s1_v;
    logic [IDX_W-1:0]  s0_index, s1_index;
    logic [PPN_W-1:0]  s0_ppn, s1_ppn;
    logic [PS_W-1:0]   s0_ps, s1_ps;
    logic [PLV_W-1:0]  s0_plv, s1_plv;
    logic [MAT_W-1:0]  s0_mat, s1_mat;
    logic [PAIR_W-1:0] pair_cnt;
    logic              search_err, search_done;

    // each block meets the wires above under their own names
    tlb_array        u_tlb_array (.*);
    tlb_write_seq    u_write_seq (.*);
    tlb_read_check   u_read_check (.*);
    tlb_search_check u_search_check (.*);
    selftest_status  u_status (.*);

endmodule

// ==== hw/tlb_write_seq.sv ====
// writes one table entry per step; entry 0 is rewritten until the first step arrives
`timescale 1ns/1ps

module tlb_write_seq
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              resetn,
    output logic              step,
    output logic              write_done,
    output logic              we,
    output logic [IDX_W-1:0]  w_index,
    output logic [IDX_W-1:0]  w_cnt,
    output logic              w_e,
    output logic [VPPN_W-1:0] w_vppn,
    output logic [PS_W-1:0]   w_ps,
    output logic [ASID_W-1:0] w_asid,
    output logic              w_g,
    output logic [PPN_W-1:0]  w_ppn0,
    output logic [PLV_W-1:0]  w_plv0,
    output logic [MAT_W-1:0]  w_mat0,
    output logic              w_d0,
    output logic              w_v0,
    output logic [PPN_W-1:0]  w_ppn1,
    output logic [PLV_W-1:0]  w_plv1,
    output logic [MAT_W-1:0]  w_mat1,
    output logic              w_d1,
    output logic              w_v1
);

    logic [STEP_W-1:0] step_cnt;

    // down counter, step is high for one cycle when it reaches zero
    always_ff @(posedge clk_g) begin
        if (!resetn || step) begin
            step_cnt <= STEP_W'(STEP_CYCLES - 1);
        end else begin
            step_cnt <= step_cnt - 1'b1;
        end
    end

    assign step = (step_cnt == '0);

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            w_cnt <= '0;
            write_done <= 1'b0;
        end else if (w_cnt == IDX_W'(TLBNUM - 1)) begin
            write_done <= 1'b1;
        end else if (step) begin
            w_cnt <= w_cnt + 1'b1;
        end
    end

    // the last entry goes in on the edge that raises write_done
    assign we = ~write_done;
    assign w_index = w_cnt;
    assign {w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0, w_mat0, w_d0, w_v0, w_ppn1, w_plv1,
            w_mat1, w_d1, w_v1} = entry_table(w_cnt);

endmodule

// ==== test/tb_tlb_selftest.sv ====
// only led and the display are observed and no fault can be injected, so test_error stays clear
`timescale 1ns/1ps

module tb_tlb_selftest
    import tlb_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;
    localparam int SLOT_CYCLES = 2 ** SCAN_SHIFT;
    // lands between write_done and the end of both checkers
    localparam int MID_CYCLES = 90;
    localparam int SCAN_WAIT = DIGITS * SLOT_CYCLES + 8;
    localparam int RUN_CYCLES = 60 * STEP_CYCLES + SCAN_WAIT;
    localparam int TIMEOUT_CYCLES = 3 * (RST_CYCLES + 1) + MID_CYCLES + 2 * RUN_CYCLES;

    // active-high a to g with a in the top bit
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
    };
    // left to right after a clean run: ids 19 and 18, then r_cnt and w_cnt
    localparam logic [3:0] FINAL_DIGITS [8] = '{
        4'h1, 4'h9, 4'h1, 4'h8, 4'h0, 4'hf, 4'h0, 4'hf
    };

    logic              clk_g = 1'b0;
    logic              resetn = 1'b0;
    logic [15:0]       led;
    logic [DIGITS-1:0] num_csn;
    logic [SEG_W-1:0]  num_a_g;

    int                cyc = 0;
    logic              dut_rst = 1'b1;
    logic [DIGITS-1:0] prev_csn = 8'hff;
    logic [SEG_W-1:0]  last_seg [DIGITS];

    tlb_selftest_top dut0 (
        .clk_g   (clk_g),
        .resetn  (resetn),
        .led     (led),
        .num_csn (num_csn),
        .num_a_g (num_a_g)
    );

    always #(CLK_PERIOD / 2) clk_g = ~clk_g;

    function automatic int clamp(input int v, input int hi);
        if (v < 0) begin
            return 0;
        end
        return (v > hi) ? hi : v;
    endfunction

    // counters and done flags k clocks after reset release, first step on clock STEP_CYCLES
    function automatic void model_state(input int k, output int w, output int r, output int p,
                                        output logic [2:0] done);
        int steps;
        steps = k / STEP_CYCLES;
        w = clamp(steps, TLBNUM - 1);
        // both checkers advance on the steps that follow write_done
        r = clamp(steps - (TLBNUM - 1), TLBNUM - 1);
        p = clamp(steps - (TLBNUM - 1), SEARCH_PAIRS - 1);
        done[2] = k > 15 * STEP_CYCLES;
        done[1] = k > 30 * STEP_CYCLES;
        done[0] = k > 27 * STEP_CYCLES;
    endfunction

    function automatic logic [15:0] ref_led(input int k);
        int         w;
        int         r;
        int         p;
        logic [2:0] done;
        model_state(k, w, r, p, done);
        return {1'b1, 12'hfff, ~done};
    endfunction

    function automatic logic [3:0] ref_digit(input int slot, input int k);
        int         w;
        int         r;
        int         p;
        logic [2:0] done;
        logic [4:0] id;
        model_state(k, w, r, p, done);
        // slots 0 and 1 show the port 1 id, slots 2 and 3 the port 0 id
        id = 5'(2 * p + ((slot < 2) ? 1 : 0));
        case (slot)
            0, 2:    return {3'b000, id[4]};
            1, 3:    return id[3:0];
            5:       return 4'(r);
            7:       return 4'(w);
            default: return 4'h0;
        endcase
    endfunction

    // digit slot of a select word with a single low bit, -1 for anything else
    function automatic int low_slot(input logic [DIGITS-1:0] csn);
        int slot;
        int lows;
        slot = -1;
        lows = 0;
        for (int i = 0; i < DIGITS; i++) begin
            if (!csn[i]) begin
                lows++;
                slot = DIGITS - 1 - i;
            end
        end
        return (lows == 1) ? slot : -1;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopped at %0t", $time);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_g);
        resetn <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk_g);
        resetn <= 1'b1;
    endtask

    task automatic wait_done();
        @(negedge clk_g);
        while (led[1:0] !== 2'b00) begin
            @(negedge clk_g);
        end
    endtask

    task automatic check_final_digits();
        for (int i = 0; i < DIGITS; i++) begin
            compare($sformatf("num_a_g slot %0d", i), last_seg[i], SEG_TABLE[FINAL_DIGITS[i]]);
        end
    endtask

    // what the DUT saw on the last edge, read before the stimulus updates land
    always @(posedge clk_g) begin
        dut_rst <= !resetn;
        cyc <= resetn ? cyc + 1 : 0;
    end

    // outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk_g) begin
        int                slot;
        logic [DIGITS-1:0] want_csn;
        if (dut_rst) begin
            compare("led", led, 16'hffff);
            compare("num_csn", num_csn, 8'hff);
            compare("num_a_g", num_a_g, 7'h00);
            foreach (last_seg[i]) begin
                last_seg[i] = '0;
            end
        end else begin
            compare("led", led, ref_led(cyc));
            want_csn = ~(8'h80 >> ((cyc - 1) / SLOT_CYCLES % DIGITS));
            compare("num_csn", num_csn, want_csn);
            // the segment pattern trails the select line by one clock
            slot = low_slot(prev_csn);
            if (slot >= 0) begin
                compare("num_a_g", num_a_g, SEG_TABLE[ref_digit(slot, cyc - 2)]);
                last_seg[slot] = num_a_g;
            end
        end
        prev_csn = num_csn;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the self-test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        apply_reset();
        wait_done();
        repeat (SCAN_WAIT) @(posedge clk_g);
        check_final_digits();
        // a fresh run that is cut short once the checkers have started
        apply_reset();
        repeat (MID_CYCLES) @(posedge clk_g);
        apply_reset();
        wait_done();
        repeat (SCAN_WAIT) @(posedge clk_g);
        check_final_digits();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tlb/tlb_array.sv ====
// entries have no reset, so searches and reads are undefined until an index has been written
`timescale 1ns/1ps

module tlb_array
    import tlb_pkg::*;
(
    input  logic              clk_g,
    input  logic              we,
    input  logic [IDX_W-1:0]  w_index,
    input  logic              w_e,
    input  logic [VPPN_W-1:0] w_vppn,
    input  logic [PS_W-1:0]   w_ps,
    input  logic [ASID_W-1:0] w_asid,
    input  logic              w_g,
    input  logic [PPN_W-1:0]  w_ppn0,
    input  logic [PLV_W-1:0]  w_plv0,
    input  logic [MAT_W-1:0]  w_mat0,
    input  logic              w_d0,
    input  logic              w_v0,
    input  logic [PPN_W-1:0]  w_ppn1,
    input  logic [PLV_W-1:0]  w_plv1,
    input  logic [MAT_W-1:0]  w_mat1,
    input  logic              w_d1,
    input  logic              w_v1,
    input  logic [IDX_W-1:0]  r_index,
    output logic              r_e,
    output logic [VPPN_W-1:0] r_vppn,
    output logic [PS_W-1:0]   r_ps,
    output logic [ASID_W-1:0] r_asid,
    output logic              r_g,
    output logic [PPN_W-1:0]  r_ppn0,
    output logic [PLV_W-1:0]  r_plv0,
    output logic [MAT_W-1:0]  r_mat0,
    output logic              r_d0,
    output logic              r_v0,
    output logic [PPN_W-1:0]  r_ppn1,
    output logic [PLV_W-1:0]  r_plv1,
    output logic [MAT_W-1:0]  r_mat1,
    output logic              r_d1,
    output logic              r_v1,
    input  logic [VPPN_W-1:0] s0_vppn,
    input  logic              s0_va_bit12,
    input  logic [ASID_W-1:0] s0_asid,
    output logic              s0_found,
    output logic [IDX_W-1:0]  s0_index,
    output logic [PPN_W-1:0]  s0_ppn,
    output logic [PS_W-1:0]   s0_ps,
    output logic [PLV_W-1:0]  s0_plv,
    output logic [MAT_W-1:0]  s0_mat,
    output logic              s0_d,
    output logic              s0_v,
    input  logic [VPPN_W-1:0] s1_vppn,
    input  logic              s1_va_bit12,
    input  logic [ASID_W-1:0] s1_asid,
    output logic              s1_found,
    output logic [IDX_W-1:0]  s1_index,
    output logic [PPN_W-1:0]  s1_ppn,
    output logic [PS_W-1:0]   s1_ps,
    output logic [PLV_W-1:0]  s1_plv,
    output logic [MAT_W-1:0]  s1_mat,
    output logic              s1_d,
    output logic              s1_v
);

    typedef struct packed {
        logic              found;
        logic [IDX_W-1:0]  index;
        logic [PPN_W-1:0]  ppn;
        logic [PS_W-1:0]   ps;
        logic [PLV_W-1:0]  plv;
        logic [MAT_W-1:0]  mat;
        logic              d;
        logic              v;
    } search_res_t;

    tlb_entry_t  mem [TLBNUM];
    search_res_t res0;
    search_res_t res1;

    // scans from the top so that the lowest matching index is the one left standing
    function automatic search_res_t lookup(input logic [VPPN_W-1:0] vppn, input logic va_bit12,
                                           input logic [ASID_W-1:0] asid);
        search_res_t res;
        logic        big;
        logic        odd;
        res = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            big = (mem[i].ps == PS_4M);
            odd = big ? vppn[BIG_LSB-1] : va_bit12;
            if (mem[i].e && (mem[i].g || mem[i].asid == asid) &&
                vppn[VPPN_W-1:BIG_LSB] == mem[i].vppn[VPPN_W-1:BIG_LSB] &&
                (big || vppn[BIG_LSB-1:0] == mem[i].vppn[BIG_LSB-1:0])) begin
                res.found = 1'b1;
                res.index = IDX_W'(i);
                res.ps = mem[i].ps;
                res.ppn = odd ? mem[i].ppn1 : mem[i].ppn0;
                res.plv = odd ? mem[i].plv1 : mem[i].plv0;
                res.mat = odd ? mem[i].mat1 : mem[i].mat0;
                res.d = odd ? mem[i].d1 : mem[i].d0;
                res.v = odd ? mem[i].v1 : mem[i].v0;
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk_g) begin
        if (we) begin
            mem[w_index] <= {w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0, w_mat0, w_d0,
                             w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1};
        end
    end

    assign {r_e, r_vppn, r_ps, r_asid, r_g, r_ppn0, r_plv0, r_mat0, r_d0, r_v0, r_ppn1, r_plv1,
            r_mat1, r_d1, r_v1} = mem[r_index];

    always_comb begin
        res0 = lookup(s0_vppn, s0_va_bit12, s0_asid);
        res1 = lookup(s1_vppn, s1_va_bit12, s1_asid);
    end

    assign {s0_found, s0_index, s0_ppn, s0_ps, s0_plv, s0_mat, s0_d, s0_v} = res0;
    assign {s1_found, s1_index, s1_ppn, s1_ps, s1_plv, s1_mat, s1_d, s1_v} = res1;

endmodule

// ==== vlog.f ====
common/tlb_pkg.sv
tlb/tlb_array.sv
hw/tlb_write_seq.sv
hw/tlb_read_check.sv
hw/tlb_search_check.sv
hw/selftest_status.sv
hw/tlb_selftest_top.sv
test/tb_tlb_selftest.sv
